// ==== project.f ====
hw/adc_monitor_pkg.sv
hw/spi_adc_master.sv
hw/peak_cache.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/command_ctrl.sv
hw/adc_monitor_top.sv
testbench/adc_monitor_checker.sv
testbench/adc_monitor_tb.sv

// ==== Bender.yml ====
package:
  name: adc_monitor

sources:
  - hw/adc_monitor_pkg.sv
  - hw/spi_adc_master.sv
  - hw/peak_cache.sv
  - hw/uart_rx.sv
  - hw/uart_tx.sv
  - hw/command_ctrl.sv
  - hw/adc_monitor_top.sv
  - target: test
    files:
      - testbench/adc_monitor_checker.sv
      - testbench/adc_monitor_tb.sv

// ==== testbench/adc_monitor_tb.sv ====
// Testbench for the ADC peak monitor with ADC and UART host models and a peak reference model
`timescale 1ns/1ps
`default_nettype none

module adc_monitor_tb;

    localparam int CLKS_PER_BIT = 16;
    localparam int SCLK_DIV     = 4;
    localparam int CLK_PERIOD   = 40;
    localparam int NUM_CH       = adc_monitor_pkg::NUM_CH;
    localparam int ADC_BITS     = adc_monitor_pkg::ADC_BITS;
    localparam int FRAME_CLKS   = (2 * ADC_BITS + 4) * SCLK_DIV;
    localparam int BYTE_CLKS    = 10 * CLKS_PER_BIT;
    // Reset reads, random rounds, clear plus reads, bad commands, bad stop bit
    localparam int NUM_CMDS     = 4 + 40 + 5 + 6 + 2;
    localparam int TOTAL_CLKS   = NUM_CMDS * (3 * FRAME_CLKS + 7 * BYTE_CLKS)
                                  + 30 * BYTE_CLKS + 4 * FRAME_CLKS + 8;
    localparam int WATCHDOG_NS  = 2 * TOTAL_CLKS * CLK_PERIOD;

    logic                clk = 1'b0;
    logic                reset_b;
    logic [NUM_CH-1:0]   miso;
    logic                sclk;
    logic                cs_n;
    logic                rxd;
    logic                txd;

    logic [31:0]         rng;
    string               test_name;
    logic [ADC_BITS-1:0] adc_val [NUM_CH];
    logic [ADC_BITS-1:0] next_val [NUM_CH];
    logic [ADC_BITS-1:0] model_peak [NUM_CH];
    logic [ADC_BITS-1:0] prev_reply [NUM_CH];
    logic                load_req;
    int                  frame_count;
    int                  bit_idx;
    logic                sclk_q;
    logic                cs_q;
    logic [7:0]          rx_q [$];

    adc_monitor_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .SCLK_DIV(SCLK_DIV)
    ) dut (
        .clk, .reset_b, .miso, .sclk, .cs_n, .rxd, .txd
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int bound_errors();
        return dut.u_cache.u_hs_chk.error_count + dut.u_tx.u_hs_chk.error_count
               + dut.u_spi.u_spi_chk.error_count;
    endfunction

    task automatic end_with_failure();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end_with_failure();
    endtask

    task automatic plain_failure(input string msg);
        $display("ERROR: %s", msg);
        end_with_failure();
    endtask

    // ADC models and reference model on the shared sclk and cs_n
    always @(posedge clk) begin
        if (!reset_b) begin
            sclk_q  = 1'b0;
            cs_q    = 1'b1;
            bit_idx = ADC_BITS - 1;
        end else begin
            if (cs_q === 1'b0 && cs_n === 1'b1) begin
                for (int ch = 0; ch < NUM_CH; ch++) begin
                    if (adc_val[ch] > model_peak[ch]) model_peak[ch] = adc_val[ch];
                end
                frame_count++;
            end
            if (cs_n === 1'b1) begin
                // New conversion values only between frames
                if (load_req) begin
                    adc_val  = next_val;
                    load_req = 1'b0;
                end
                bit_idx = ADC_BITS - 1;
                for (int ch = 0; ch < NUM_CH; ch++) miso[ch] <= adc_val[ch][ADC_BITS-1];
            end else if (sclk_q === 1'b1 && sclk === 1'b0 && bit_idx > 0) begin
                bit_idx--;
                for (int ch = 0; ch < NUM_CH; ch++) miso[ch] <= adc_val[ch][bit_idx];
            end
            sclk_q = sclk;
            cs_q   = cs_n;
        end
    end

    // Host side receiver decoding every byte seen on txd
    initial begin
        logic [7:0] data;
        wait (reset_b === 1'b1);
        forever begin
            @(posedge clk);
            if (txd === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(posedge clk);
                assert (txd === 1'b0) else plain_failure("start bit on txd ended early");
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(posedge clk);
                    data[i] = txd;
                end
                repeat (CLKS_PER_BIT) @(posedge clk);
                assert (txd === 1'b1) else plain_failure("stop bit on txd was low");
                rx_q.push_back(data);
            end
        end
    end

    always @(posedge clk) begin
        if (reset_b) begin
            assert (bound_errors() == 0) else plain_failure("a bound protocol assertion failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        plain_failure("watchdog expired, the DUT stopped responding");
    end

    // One 8N1 frame on rxd followed by one idle bit
    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        rxd <= 1'b1;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic wait_reply(input int count, input int limit_bytes);
        int waited;
        waited = 0;
        while (rx_q.size() < count) begin
            @(posedge clk);
            waited++;
            assert (waited <= limit_bytes * BYTE_CLKS)
                else plain_failure($sformatf("%s: reply missing after %0d byte times",
                                             test_name, limit_bytes));
        end
    endtask

    task automatic wait_frames(input int count);
        int target;
        target = frame_count + count;
        while (frame_count < target) @(posedge clk);
    endtask

    // Load random ADC values and let two whole frames of them complete
    task automatic load_values(input logic [ADC_BITS-1:0] mask);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            rng          = xorshift32(rng);
            next_val[ch] = rng[ADC_BITS-1:0] & mask;
        end
        load_req = 1'b1;
        while (load_req) @(posedge clk);
        wait_frames(2);
    endtask

    task automatic read_channel(input int ch);
        logic [7:0]  hi;
        logic [7:0]  lo;
        logic [15:0] actual;
        send_byte(8'(adc_monitor_pkg::cmd_ch_base + ch), 1'b1);
        wait_reply(2, 4);
        hi     = rx_q.pop_front();
        lo     = rx_q.pop_front();
        actual = {hi, lo};
        assert (actual >= 16'(prev_reply[ch]))
            else plain_failure($sformatf("%s: peak of channel %0d fell from 0x%0h to 0x%0h",
                                         test_name, ch + 1, prev_reply[ch], actual));
        assert (actual == 16'(model_peak[ch]))
            else value_mismatch($sformatf("%s ch%0d", test_name, ch + 1),
                                16'(model_peak[ch]), actual);
        prev_reply[ch] = actual[ADC_BITS-1:0];
    endtask

    initial begin
        logic [7:0] got;
        logic [7:0] bad;
        int         ch;
        reset_b     = 1'b0;
        rxd         = 1'b1;
        miso        = '0;
        load_req    = 1'b0;
        frame_count = 0;
        rng         = 32'hf767_595c;
        adc_val     = '{default: '0};
        next_val    = '{default: '0};
        model_peak  = '{default: '0};
        prev_reply  = '{default: '0};
        repeat (8) @(posedge clk);
        reset_b <= 1'b1;

        test_name = "reset_read";
        load_values('1);
        for (int i = 0; i < NUM_CH; i++) read_channel(i);

        test_name = "random_rounds";
        repeat (40) begin
            load_values('1);
            rng = xorshift32(rng);
            read_channel(int'(rng[1:0]));
        end

        // Small values held across the clear so later peaks drop below older ones
        test_name = "clear";
        load_values(10'h0ff);
        send_byte(adc_monitor_pkg::cmd_clear_char, 1'b1);
        wait_reply(1, 4);
        got = rx_q.pop_front();
        assert (got == adc_monitor_pkg::reply_ok)
            else value_mismatch(test_name, adc_monitor_pkg::reply_ok, got);
        model_peak = '{default: '0};
        prev_reply = '{default: '0};
        wait_frames(2);
        load_values(10'h07f);
        for (int i = 0; i < NUM_CH; i++) read_channel(i);

        test_name = "bad_command";
        repeat (3) begin
            do begin
                rng = xorshift32(rng);
                bad = rng[7:0];
            end while (bad == adc_monitor_pkg::cmd_clear_char ||
                       (bad >= adc_monitor_pkg::cmd_ch_base &&
                        bad < adc_monitor_pkg::cmd_ch_base + NUM_CH));
            wait_frames(2);
            send_byte(bad, 1'b1);
            wait_reply(1, 4);
            got = rx_q.pop_front();
            assert (got == adc_monitor_pkg::reply_bad)
                else value_mismatch(test_name, adc_monitor_pkg::reply_bad, got);
            repeat (3 * BYTE_CLKS) @(posedge clk);
            assert (rx_q.size() == 0)
                else value_mismatch({test_name, " extra bytes"}, 0, rx_q.size());
            rng = xorshift32(rng);
            read_channel(int'(rng[1:0]));
        end

        test_name = "bad_stop";
        wait_frames(2);
        rng = xorshift32(rng);
        ch  = int'(rng[1:0]);
        send_byte(8'(adc_monitor_pkg::cmd_ch_base + ch), 1'b0);
        repeat (30 * BYTE_CLKS) @(posedge clk);
        assert (rx_q.size() == 0) else value_mismatch(test_name, 0, rx_q.size());
        read_channel(ch);

        if (bound_errors() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            plain_failure("a bound protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/adc_monitor_checker.sv ====
// Bound protocol checker for the four-phase handshakes and the SPI chip select framing
`timescale 1ns/1ps
`default_nettype none

module adc_monitor_checker (
    input wire logic clk,
    input wire logic reset_b,
    input wire logic req,
    input wire logic ack,
    input wire logic sclk,
    input wire logic cs_n
);

    // Read by the testbench to spot failures as they happen
    int error_count = 0;

    // Request held until the acknowledge arrives
    req_held: assert property (@(posedge clk) disable iff (!reset_b) req && !ack |=> req)
        else begin
            error_count++;
            $error("request dropped before its acknowledge");
        end

    // Acknowledge only released after the request is gone
    ack_held: assert property (@(posedge clk) disable iff (!reset_b) ack && req |=> ack)
        else begin
            error_count++;
            $error("acknowledge dropped while request still high");
        end

    // Serial clock parked low between frames
    sclk_idle: assert property (@(posedge clk) disable iff (!reset_b) cs_n |-> !sclk)
        else begin
            error_count++;
            $error("sclk high while cs_n is high");
        end

endmodule

bind peak_cache adc_monitor_checker u_hs_chk (
    .clk, .reset_b, .req(cache_req), .ack(cache_ack), .sclk(1'b0), .cs_n(1'b1)
);

bind uart_tx adc_monitor_checker u_hs_chk (
    .clk, .reset_b, .req(tx_req), .ack(tx_ack), .sclk(1'b0), .cs_n(1'b1)
);

bind spi_adc_master adc_monitor_checker u_spi_chk (
    .clk, .reset_b, .req(1'b0), .ack(1'b0), .sclk, .cs_n
);

`default_nettype wire

// ==== hw/adc_monitor_top.sv ====
// Four-channel ADC peak monitor with a UART command port
`timescale 1ns/1ps
`default_nettype none

module adc_monitor_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int SCLK_DIV     = 4
) (
    input  wire logic                                clk,
    input  wire logic                                reset_b,
    input  wire logic [adc_monitor_pkg::NUM_CH-1:0]  miso,
    output logic                                     sclk,
    output logic                                     cs_n,
    input  wire logic                                rxd,
    output logic                                     txd
);

    logic                                  sample_valid;
    adc_monitor_pkg::sample_frame_t        frames;
    logic                                  cache_req;
    adc_monitor_pkg::cache_req_t           req;
    logic                                  cache_ack;
    logic [adc_monitor_pkg::ADC_BITS-1:0]  peak_value;
    logic                                  rx_valid;
    logic [7:0]                            rx_byte;
    logic                                  tx_req;
    logic [7:0]                            tx_byte;
    logic                                  tx_ack;

    spi_adc_master #(.SCLK_DIV(SCLK_DIV)) u_spi (
        .clk, .reset_b, .miso, .sclk, .cs_n, .sample_valid, .frames
    );

    peak_cache u_cache (
        .clk, .reset_b, .sample_valid, .frames,
        .cache_req, .req, .cache_ack, .peak_value
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk, .reset_b, .rxd, .rx_valid, .rx_byte
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk, .reset_b, .tx_req, .tx_byte, .tx_ack, .txd
    );

    command_ctrl u_ctrl (
        .clk, .reset_b, .rx_valid, .rx_byte,
        .cache_req, .req, .cache_ack, .peak_value,
        .tx_req, .tx_byte, .tx_ack
    );

endmodule

`default_nettype wire

// ==== hw/command_ctrl.sv ====
// Command decoder sequencing cache access and reply bytes for the serial host
`timescale 1ns/1ps
`default_nettype none

module command_ctrl (
    input  wire logic                                clk,
    input  wire logic                                reset_b,
    input  wire logic                                rx_valid,
    input  wire logic [7:0]                          rx_byte,
    output logic                                     cache_req,
    output adc_monitor_pkg::cache_req_t              req,
    input  wire logic                                cache_ack,
    input  wire logic [adc_monitor_pkg::ADC_BITS-1:0] peak_value,
    output logic                                     tx_req,
    output logic [7:0]                               tx_byte,
    input  wire logic                                tx_ack
);

    typedef enum logic [2:0] {
        idle, cache_wait, cache_release, send_hi, send_lo, send_single, tx_release
    } state_t;

    state_t                                state;
    adc_monitor_pkg::cmd_op_e              rx_op;
    logic [7:0]                            ch_offset;
    logic [adc_monitor_pkg::ADC_BITS-1:0]  peak_q;
    logic [7:0]                            single_q;
    logic                                  lo_pending;

    // Digits map onto channels, anything outside the range is rejected
    assign ch_offset = rx_byte - adc_monitor_pkg::cmd_ch_base;
    always_comb begin
        if (rx_byte == adc_monitor_pkg::cmd_clear_char) rx_op = adc_monitor_pkg::op_clear;
        else if (ch_offset < adc_monitor_pkg::NUM_CH)   rx_op = adc_monitor_pkg::op_read;
        else                                            rx_op = adc_monitor_pkg::op_none;
    end

    assign cache_req = (state == cache_wait);
    assign tx_req    = (state == send_hi) || (state == send_lo) || (state == send_single);

    always_comb begin
        case (state)
            send_hi: tx_byte = 8'(peak_q[adc_monitor_pkg::ADC_BITS-1:8]);
            send_lo: tx_byte = peak_q[7:0];
            default: tx_byte = single_q;
        endcase
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state      <= idle;
            req        <= '{op: adc_monitor_pkg::op_none, channel: '0};
            lo_pending <= 1'b0;
        end else begin
            case (state)
                // Strobes arriving in any other state are lost
                idle: begin
                    if (rx_valid) begin
                        req.op      <= rx_op;
                        req.channel <= ch_offset[adc_monitor_pkg::CH_BITS-1:0];
                        state <= (rx_op == adc_monitor_pkg::op_none) ? send_single : cache_wait;
                    end
                end
                cache_wait:    if (cache_ack) state <= cache_release;
                cache_release: begin
                    if (!cache_ack) begin
                        state <= (req.op == adc_monitor_pkg::op_read) ? send_hi : send_single;
                    end
                end
                send_hi: begin
                    if (tx_ack) begin
                        lo_pending <= 1'b1;
                        state      <= tx_release;
                    end
                end
                send_lo: begin
                    if (tx_ack) begin
                        lo_pending <= 1'b0;
                        state      <= tx_release;
                    end
                end
                send_single:   if (tx_ack) state <= tx_release;
                tx_release:    if (!tx_ack) state <= lo_pending ? send_lo : idle;
                default:       state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && rx_valid) begin
            single_q <= (rx_op == adc_monitor_pkg::op_clear) ? adc_monitor_pkg::reply_ok
                                                             : adc_monitor_pkg::reply_bad;
        end
        if (state == cache_wait && cache_ack) begin
            peak_q <= peak_value;
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
// 8N1 UART transmitter taking one byte per four-phase request
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic        clk,
    input  wire logic        reset_b,
    input  wire logic        tx_req,
    input  wire logic [7:0]  tx_byte,
    output logic             tx_ack,
    output logic             txd
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {idle, sending, done} state_t;

    state_t           state;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;
    logic [8:0]       data_q;

    assign tx_ack = (state == done);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state   <= idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                idle: begin
                    if (tx_req) begin
                        txd     <= 1'b0;
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= sending;
                    end
                end
                sending: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        // Ten bit periods incl. the stop bit
                        if (bit_idx == 4'd9) state <= done;
                        else txd <= data_q[0];
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                done: if (!tx_req) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Data bits then the stop bit, ones fill in behind
    always_ff @(posedge clk) begin
        if (state == idle && tx_req) begin
            data_q <= {1'b1, tx_byte};
        end else if (state == sending && clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            data_q <= {1'b1, data_q[8:1]};
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
// 8N1 UART receiver with mid-bit sampling and a single-cycle byte strobe
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic        clk,
    input  wire logic        reset_b,
    input  wire logic        rxd,
    output logic             rx_valid,
    output logic [7:0]       rx_byte
);

    localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {idle, start, data, stop} state_t;

    state_t           state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_prev;
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state    <= idle;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                idle: begin
                    clk_cnt <= '0;
                    // Falling edge only, so a held-low line is not a new start
                    if (rxd_prev && !rxd_sync) state <= start;
                end
                start: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? idle : data;
                    end
                end
                data: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= stop;
                    end
                end
                stop: begin
                    if (bit_end) begin
                        // Bad stop bit drops the byte silently
                        rx_valid <= rxd_sync;
                        state    <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == data && bit_end) begin
            rx_byte <= {rxd_sync, rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== hw/peak_cache.sv ====
// Per-channel running maximum with read and clear served over a four-phase handshake
`timescale 1ns/1ps
`default_nettype none

module peak_cache (
    input  wire logic                                   clk,
    input  wire logic                                   reset_b,
    input  wire logic                                   sample_valid,
    input  wire adc_monitor_pkg::sample_frame_t         frames,
    input  wire logic                                   cache_req,
    input  wire adc_monitor_pkg::cache_req_t            req,
    output logic                                        cache_ack,
    output logic [adc_monitor_pkg::ADC_BITS-1:0]        peak_value
);

    typedef enum logic {waiting, acking} state_t;

    state_t                                                            state;
    logic [adc_monitor_pkg::NUM_CH-1:0][adc_monitor_pkg::ADC_BITS-1:0] peaks;
    logic                                                              take_req;
    logic                                                              clear_now;

    // New request only counts while the previous ack is down
    assign take_req  = (state == waiting) && cache_req;
    assign clear_now = take_req && (req.op == adc_monitor_pkg::op_clear);
    assign cache_ack = (state == acking);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= waiting;
        end else begin
            case (state)
                waiting: if (cache_req) state <= acking;
                acking:  if (!cache_req) state <= waiting;
                default: state <= waiting;
            endcase
        end
    end

    // Clear has priority over a frame arriving in the same cycle
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            peaks <= '0;
        end else if (clear_now) begin
            peaks <= '0;
        end else if (sample_valid) begin
            for (int ch = 0; ch < adc_monitor_pkg::NUM_CH; ch++) begin
                if (frames.sample[ch] > peaks[ch]) begin
                    peaks[ch] <= frames.sample[ch];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_req) begin
            peak_value <= (req.op == adc_monitor_pkg::op_read) ? peaks[req.channel] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/spi_adc_master.sv ====
// SPI master reading all ADC channels in parallel on a shared serial clock and chip select
`timescale 1ns/1ps
`default_nettype none

module spi_adc_master #(
    parameter int SCLK_DIV = 4
) (
    input  wire logic                                 clk,
    input  wire logic                                 reset_b,
    input  wire logic [adc_monitor_pkg::NUM_CH-1:0]   miso,
    output logic                                      sclk,
    output logic                                      cs_n,
    output logic                                      sample_valid,
    output adc_monitor_pkg::sample_frame_t            frames
);

    localparam int DIV_W      = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    localparam int BIT_W      = $clog2(adc_monitor_pkg::ADC_BITS);
    // Chip select high time, counted in sclk half periods
    localparam int GAP_HALVES = 4;

    typedef enum logic {idle_gap, shifting} state_t;

    state_t                                                        state;
    logic [DIV_W-1:0]                                              div_cnt;
    logic [BIT_W-1:0]                                              bit_cnt;
    logic                                                          tick;
    logic                                                          frame_done;
    logic [adc_monitor_pkg::NUM_CH-1:0][adc_monitor_pkg::ADC_BITS-1:0] shift_q;

    // One tick per sclk half period
    assign tick = (div_cnt == DIV_W'(SCLK_DIV - 1));

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state      <= idle_gap;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            sclk       <= 1'b0;
            cs_n       <= 1'b1;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (tick) begin
                div_cnt <= '0;
                case (state)
                    idle_gap: begin
                        // Bit counter doubles as the gap counter here
                        if (bit_cnt == BIT_W'(GAP_HALVES - 1)) begin
                            bit_cnt <= '0;
                            cs_n    <= 1'b0;
                            state   <= shifting;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    shifting: begin
                        sclk <= ~sclk;
                        if (!sclk) begin
                            // Rising edge, last bit closes the frame
                            frame_done <= (bit_cnt == BIT_W'(adc_monitor_pkg::ADC_BITS - 1));
                        end else if (bit_cnt == BIT_W'(adc_monitor_pkg::ADC_BITS - 1)) begin
                            bit_cnt <= '0;
                            cs_n    <= 1'b1;
                            state   <= idle_gap;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: state <= idle_gap;
                endcase
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Sample MISO where sclk goes high, MSB first
    always_ff @(posedge clk) begin
        if (state == shifting && tick && !sclk) begin
            for (int ch = 0; ch < adc_monitor_pkg::NUM_CH; ch++) begin
                shift_q[ch] <= {shift_q[ch][adc_monitor_pkg::ADC_BITS-2:0], miso[ch]};
            end
        end
        if (frame_done) begin
            frames.sample <= shift_q;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= frame_done;
        end
    end

endmodule

`default_nettype wire

// ==== hw/adc_monitor_pkg.sv ====
// ADC peak monitor shared constants, command opcodes and bundled types
`default_nettype none

package adc_monitor_pkg;

    // Channel count and sample width are fixed for this design
    localparam int NUM_CH   = 4;
    localparam int ADC_BITS = 10;
    localparam int CH_BITS  = $clog2(NUM_CH);

    // One sample per channel, channel 0 in the low slice
    typedef struct packed {
        logic [NUM_CH-1:0][ADC_BITS-1:0] sample;
    } sample_frame_t;

    // Operation requested from the peak cache
    typedef enum logic [1:0] {
        op_read,
        op_clear,
        op_none
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e              op;
        logic [CH_BITS-1:0]   channel;
    } cache_req_t;

    // ASCII command and reply codes
    localparam logic [7:0] reply_ok       = 8'h4B;  // 'K'
    localparam logic [7:0] reply_bad      = 8'h3F;  // '?'
    localparam logic [7:0] cmd_clear_char = 8'h43;  // 'C'
    localparam logic [7:0] cmd_ch_base    = 8'h31;  // '1'

endpackage

`default_nettype wire
